// ==== src/dsp_pkg.sv ====
package dsp_pkg;

    // Fixed-point format shared by samples, coefficients, products and sums
    localparam int DATA_SIZE = 32;
    localparam int FRAC_BITS = 10;

    // Filter geometry. UNROLL_FACTOR has to divide NUM_TAPS
    localparam int NUM_TAPS = 8;
    localparam int DECIMATION = 4;
    localparam int UNROLL_FACTOR = 2;
    localparam int SLICES = NUM_TAPS / UNROLL_FACTOR;
    localparam int TAP_INDEX_WIDTH = $clog2(NUM_TAPS);
    localparam int DECIMATION_WIDTH = $clog2(DECIMATION);

    typedef logic signed [DATA_SIZE-1:0] sample_t;

    // Symmetric low-pass set in Q10 with unity DC gain (taps sum to 1024)
    localparam sample_t COEFFICIENTS [NUM_TAPS] = '{-16, 24, 152, 352, 352, 152, 24, -16};

    typedef enum logic [1:0] {
        S_LOAD,
        S_MULTIPLY,
        S_ACCUMULATE,
        S_WRITE
    } fir_state_t;

    typedef struct packed {
        logic shift;
        logic multiply;
        logic accumulate;
        logic clear;
    } fir_control_t;

    typedef struct packed {
        logic                       decimation_done;
        logic                       unroll_last;
        logic [TAP_INDEX_WIDTH-1:0] unroll_index;
    } fir_phase_t;

    // Full-width product, rounded by half an LSB and scaled back to Q10
    function automatic sample_t multiply_rounding(input sample_t a, input sample_t b);
        logic signed [2*DATA_SIZE-1:0] product;
        product = a * b;
        product = product + (64'sd1 <<< (FRAC_BITS - 1));
        product = product >>> FRAC_BITS;
        return product[DATA_SIZE-1:0];
    endfunction

endpackage

// ==== src/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
    parameter int DEPTH = 16
) (
    input  logic             clock,
    input  logic             reset,
    input  dsp_pkg::sample_t din,
    input  logic             wr_en,
    output logic             full,
    output dsp_pkg::sample_t dout,
    input  logic             rd_en,
    output logic             empty
);
    import dsp_pkg::*;

    sample_t mem [DEPTH];

    // The top pointer bit flips on every lap and separates full from empty
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en && !full) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= din;
        end
    end

    // Show-ahead read port, the head word is visible while empty is low
    assign dout = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)]) &&
                  (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]);

    assert property (@(posedge clock) disable iff (reset) wr_en |-> !full)
        else $error("FIFO written while full");

    assert property (@(posedge clock) disable iff (reset) rd_en |-> !empty)
        else $error("FIFO read while empty");

endmodule

// ==== src/fir_sequencer.sv ====
`timescale 1ns/1ps

module fir_sequencer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_empty,
    output logic                  in_rd_en,
    input  logic                  out_full,
    output logic                  out_wr_en,
    input  dsp_pkg::fir_phase_t   phase,
    output dsp_pkg::fir_control_t control
);
    import dsp_pkg::*;

    fir_state_t state;
    fir_state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= S_LOAD;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_LOAD: begin
                // Leave on the read that completes the decimation group
                if (!in_empty && phase.decimation_done) begin
                    next_state = S_MULTIPLY;
                end
            end
            S_MULTIPLY: begin
                if (phase.unroll_last) begin
                    next_state = S_ACCUMULATE;
                end
            end
            S_ACCUMULATE: begin
                next_state = S_WRITE;
            end
            S_WRITE: begin
                if (!out_full) begin
                    next_state = S_LOAD;
                end
            end
            default: begin
                next_state = S_LOAD;
            end
        endcase
    end

    // One FIFO read is one shift, one FIFO write clears the sum
    assign in_rd_en = (state == S_LOAD) && !in_empty;
    assign out_wr_en = (state == S_WRITE) && !out_full;

    assign control.shift = in_rd_en;
    assign control.multiply = (state == S_MULTIPLY);
    assign control.accumulate = (state == S_ACCUMULATE);
    assign control.clear = out_wr_en;

    assert property (@(posedge clock) disable iff (reset)
        !$isunknown(state) && (state inside {S_LOAD, S_MULTIPLY, S_ACCUMULATE, S_WRITE}))
        else $error("Sequencer state left the encoded values");

    // The counter has to end the multiply passes after exactly one sweep of the taps
    assert property (@(posedge clock) disable iff (reset)
        (in_rd_en && phase.decimation_done) |=>
            (state == S_MULTIPLY) [*SLICES] ##1 (state == S_ACCUMULATE))
        else $error("Multiply phase did not last one pass per slice");

endmodule

// ==== src/fir_phase_counter.sv ====
`timescale 1ns/1ps

module fir_phase_counter (
    input  logic                  clock,
    input  logic                  reset,
    input  dsp_pkg::fir_control_t control,
    output dsp_pkg::fir_phase_t   phase
);
    import dsp_pkg::*;

    logic [DECIMATION_WIDTH-1:0] decimation_count;
    logic [TAP_INDEX_WIDTH-1:0]  unroll_index;
    logic                        decimation_done;
    logic                        unroll_last;

    assign decimation_done = (decimation_count == DECIMATION_WIDTH'(DECIMATION - 1));
    assign unroll_last = (unroll_index == TAP_INDEX_WIDTH'(NUM_TAPS - UNROLL_FACTOR));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            decimation_count <= '0;
            unroll_index <= '0;
        end else begin
            if (control.shift) begin
                decimation_count <= decimation_done ? '0 : decimation_count + 1'b1;
            end
            // Slice start steps through the taps and is back at zero for the next output
            if (control.multiply) begin
                if (unroll_last) begin
                    unroll_index <= '0;
                end else begin
                    unroll_index <= unroll_index + TAP_INDEX_WIDTH'(UNROLL_FACTOR);
                end
            end
        end
    end

    assign phase.decimation_done = decimation_done;
    assign phase.unroll_last = unroll_last;
    assign phase.unroll_index = unroll_index;

endmodule

// ==== src/fir_delay_line.sv ====
`timescale 1ns/1ps

module fir_delay_line (
    input  logic                  clock,
    input  logic                  reset,
    input  dsp_pkg::fir_control_t control,
    input  dsp_pkg::sample_t      sample,
    output dsp_pkg::sample_t      taps [dsp_pkg::NUM_TAPS]
);
    import dsp_pkg::*;

    // Tap 0 holds the newest sample, the last tap the oldest
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (control.shift) begin
            taps[0] <= sample;
            for (int i = 1; i < NUM_TAPS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

endmodule

// ==== src/fir_mac.sv ====
`timescale 1ns/1ps

module fir_mac (
    input  logic                                 clock,
    input  logic                                 reset,
    input  dsp_pkg::fir_control_t                control,
    input  dsp_pkg::sample_t                     taps [dsp_pkg::NUM_TAPS],
    input  logic [dsp_pkg::TAP_INDEX_WIDTH-1:0] unroll_index,
    output dsp_pkg::sample_t                     sum
);
    import dsp_pkg::*;

    sample_t products [NUM_TAPS];
    sample_t total;

    // Adder tree over the stored products, wrapping at the sample width
    always_comb begin
        total = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            total = total + products[i];
        end
    end

    // Each multiply pass fills one slice of UNROLL_FACTOR products
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                products[i] <= '0;
            end
        end else if (control.multiply) begin
            for (int k = 0; k < UNROLL_FACTOR; k++) begin
                // Coefficients are applied in reverse tap order
                products[unroll_index + k] <= multiply_rounding(
                    taps[unroll_index + k],
                    COEFFICIENTS[NUM_TAPS - 1 - (unroll_index + k)]);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sum <= '0;
        end else if (control.clear) begin
            sum <= '0;
        end else if (control.accumulate) begin
            sum <= sum + total;
        end
    end

endmodule

// ==== src/fir_filter_top.sv ====
`timescale 1ns/1ps

module fir_filter_top (
    input  logic             clock,
    input  logic             reset,
    input  dsp_pkg::sample_t in_din,
    input  logic             in_wr_en,
    output logic             in_full,
    input  logic             out_rd_en,
    output dsp_pkg::sample_t out_dout,
    output logic             out_empty
);
    import dsp_pkg::*;

    sample_t      in_dout;
    logic         in_empty;
    logic         in_rd_en;
    sample_t      out_din;
    logic         out_full;
    logic         out_wr_en;
    fir_control_t control;
    fir_phase_t   phase;
    sample_t      taps [NUM_TAPS];

    sample_fifo u_in_fifo (
        .clock (clock),
        .reset (reset),
        .din   (in_din),
        .wr_en (in_wr_en),
        .full  (in_full),
        .dout  (in_dout),
        .rd_en (in_rd_en),
        .empty (in_empty)
    );

    fir_sequencer u_sequencer (
        .clock     (clock),
        .reset     (reset),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .out_full  (out_full),
        .out_wr_en (out_wr_en),
        .phase     (phase),
        .control   (control)
    );

    fir_phase_counter u_phase_counter (
        .clock   (clock),
        .reset   (reset),
        .control (control),
        .phase   (phase)
    );

    fir_delay_line u_delay_line (
        .clock   (clock),
        .reset   (reset),
        .control (control),
        .sample  (in_dout),
        .taps    (taps)
    );

    fir_mac u_mac (
        .clock        (clock),
        .reset        (reset),
        .control      (control),
        .taps         (taps),
        .unroll_index (phase.unroll_index),
        .sum          (out_din)
    );

    sample_fifo u_out_fifo (
        .clock (clock),
        .reset (reset),
        .din   (out_din),
        .wr_en (out_wr_en),
        .full  (out_full),
        .dout  (out_dout),
        .rd_en (out_rd_en),
        .empty (out_empty)
    );

endmodule

// ==== bench/fir_filter_tb.sv ====
`timescale 1ns/1ps

module fir_filter_tb;
    import dsp_pkg::*;

    localparam time PERIOD = 40ns;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_FILL_SAMPLES = 200;
    // Longer than any pause of the sequencer between two input reads
    localparam int STALL_CYCLES = 16;
    // Every sample of every test, with the back-pressure fill taken at its limit
    localparam int TOTAL_SAMPLES = 12 + 62 + 40 + MAX_FILL_SAMPLES + 11 + 32;
    localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 20 + 400;

    logic    clock;
    logic    reset;
    sample_t in_din;
    logic    in_wr_en;
    logic    in_full;
    logic    out_rd_en;
    sample_t out_dout;
    logic    out_empty;

    integer  seed;
    string   test_name;
    logic    hold_reads;
    int      writes_total;
    int      reads_total;
    int      value_errors;
    int      other_errors;
    int      group_count;
    sample_t history [$];
    sample_t expected_outputs [$];
    sample_t expected_value;

    fir_filter_top UUT (
        .clock     (clock),
        .reset     (reset),
        .in_din    (in_din),
        .in_wr_en  (in_wr_en),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reference model, history[0] is the newest sample
    task automatic model_sample(input sample_t value);
        sample_t acc;
        history.push_front(value);
        void'(history.pop_back());
        group_count++;
        if (group_count == DECIMATION) begin
            group_count = 0;
            acc = '0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                acc = acc + multiply_rounding(history[i], COEFFICIENTS[NUM_TAPS-1-i]);
            end
            expected_outputs.push_back(acc);
        end
    endtask

    // Called 2 ns after a rising edge and returns at the same point of a later cycle
    task automatic write_sample(input sample_t value);
        while (in_full) begin
            @(posedge clock);
            #2;
        end
        in_din = value;
        in_wr_en = 1'b1;
        model_sample(value);
        writes_total++;
        @(posedge clock);
        #2;
        in_wr_en = 1'b0;
    endtask

    task automatic drain_outputs;
        while (expected_outputs.size() > 0) begin
            @(posedge clock);
        end
        repeat (8) @(posedge clock);
        #2;
        if (reads_total != writes_total / DECIMATION) begin
            value_errors++;
            $display("error %s expected %0d outputs actual %0d outputs",
                     test_name, writes_total / DECIMATION, reads_total);
        end
    endtask

    // Reader keeps the output FIFO drained unless the bench holds it back
    initial begin
        out_rd_en = 1'b0;
        @(negedge reset);
        forever begin
            @(posedge clock);
            #2;
            out_rd_en = !hold_reads && !out_empty;
        end
    end

    always @(posedge clock) begin
        if (!reset && out_rd_en) begin
            reads_total++;
            if (expected_outputs.size() == 0) begin
                other_errors++;
                $display("Output %0d read in test %s with no expected value pending",
                         out_dout, test_name);
            end else begin
                expected_value = expected_outputs.pop_front();
                assert (out_dout == expected_value) else begin
                    value_errors++;
                    $display("error %s expected %0d actual %0d",
                             test_name, expected_value, out_dout);
                end
            end
        end
    end

    assert property (@(posedge clock) reset |-> (out_empty && !in_full)) else begin
        other_errors++;
        $display("FIFO levels wrong during reset");
    end

    assert property (@(posedge clock) disable iff (reset)
        (writes_total < DECIMATION) |-> out_empty) else begin
        other_errors++;
        $display("Output appeared before four samples were written");
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired in test %s before the run completed", test_name);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int      fill_count;
        int      full_cycles;
        sample_t value;
        seed = 23880;
        reset = 1'b1;
        in_din = '0;
        in_wr_en = 1'b0;
        hold_reads = 1'b0;
        writes_total = 0;
        reads_total = 0;
        value_errors = 0;
        other_errors = 0;
        group_count = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            history.push_back('0);
        end

        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
        repeat (4) @(posedge clock);
        #2;

        test_name = "impulse";
        write_sample(32'sd1024);
        for (int i = 0; i < 11; i++) begin
            write_sample('0);
        end
        drain_outputs();

        test_name = "random";
        for (int i = 0; i < 62; i++) begin
            write_sample($random(seed) >>> 12);
        end
        drain_outputs();

        test_name = "gaps";
        for (int i = 0; i < 40; i++) begin
            write_sample($random(seed) >>> 12);
            repeat ({$random(seed)} % 4) begin
                @(posedge clock);
                #2;
            end
        end
        drain_outputs();

        // Output FIFO fills first, then the stalled sequencer lets the input FIFO fill
        // An input FIFO that stays full means the sequencer is held in its write state
        test_name = "backpressure";
        hold_reads = 1'b1;
        fill_count = 0;
        full_cycles = 0;
        while (full_cycles < STALL_CYCLES && fill_count < MAX_FILL_SAMPLES) begin
            if (in_full) begin
                full_cycles++;
                @(posedge clock);
                #2;
            end else begin
                full_cycles = 0;
                write_sample($random(seed) >>> 12);
                fill_count++;
            end
        end
        if (full_cycles < STALL_CYCLES) begin
            other_errors++;
            $display("Input FIFO never stayed full while output reads were held");
        end
        hold_reads = 1'b0;
        drain_outputs();

        // Extreme samples against the tap signs push one sum past the 32-bit range
        test_name = "wrap";
        while (group_count != 0) begin
            write_sample('0);
        end
        write_sample(32'sh8000_0000);
        for (int i = 0; i < NUM_TAPS - 2; i++) begin
            write_sample(32'sh7fff_ffff);
        end
        write_sample(32'sh8000_0000);
        for (int i = 0; i < 32; i++) begin
            value = $random(seed);
            value[DATA_SIZE-2] = !value[DATA_SIZE-1];
            write_sample(value);
        end
        drain_outputs();
        repeat (40) @(posedge clock);

        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/dsp_pkg.sv
src/sample_fifo.sv
src/fir_sequencer.sv
src/fir_phase_counter.sv
src/fir_delay_line.sv
src/fir_mac.sv
src/fir_filter_top.sv
bench/fir_filter_tb.sv

// ==== Bender.yml ====
package:
  name: fir_filter

sources:
  - src/dsp_pkg.sv
  - src/sample_fifo.sv
  - src/fir_sequencer.sv
  - src/fir_phase_counter.sv
  - src/fir_delay_line.sv
  - src/fir_mac.sv
  - src/fir_filter_top.sv
  - target: test
    files:
      - bench/fir_filter_tb.sv
